/* Bender.yml */
package:
  name: axi_sram

sources:
  - hdl/axi_sram_pkg.sv
  - hdl/chan_hold.sv
  - hdl/lfsr_delay.sv
  - hdl/sram_array.sv
  - hdl/axi_sram_ctrl.sv
  - hdl/axi_sram_top.sv
  - target: simulation
    files:
      - tb/tb_axi_sram.sv

/* hdl/axi_sram_ctrl.sv */
module axi_sram_ctrl (
    input  logic                             aclk,
    input  logic                             areset_n,
    input  logic                             aw_full_i,
    input  logic                             w_full_i,
    input  logic                             ar_full_i,
    input  logic                             w_ok_i,
    input  logic                             r_ok_i,
    input  axi_sram_pkg::data_t              rdata_i,
    input  logic [axi_sram_pkg::DELAY_W-1:0] delay_i,
    input  logic                             bready_i,
    input  logic                             rready_i,
    output logic                             aw_clear_o,
    output logic                             w_clear_o,
    output logic                             ar_clear_o,
    output logic                             we_o,
    output logic                             re_o,
    output logic                             take_o,
    output logic                             bvalid_o,
    output axi_sram_pkg::resp_t              bresp_o,
    output logic                             rvalid_o,
    output axi_sram_pkg::data_t              rdata_o,
    output axi_sram_pkg::resp_t              rresp_o
);

    import axi_sram_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_WAIT, W_RESP} w_state_t;
    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_WAIT, R_RESP} r_state_t;

    w_state_t           w_state;
    r_state_t           r_state;
    logic [DELAY_W-1:0] w_cnt;
    logic [DELAY_W-1:0] r_cnt;
    resp_t              bresp_q;
    resp_t              rresp_q;
    data_t              rdata_q;
    logic               w_fire;
    logic               r_load;

    // both halves of the write are in, do it now
    assign w_fire = (w_state == W_IDLE) && aw_full_i && w_full_i;

    // write owns the delay value when both want one
    assign r_load = (r_state == R_FETCH) && !w_fire;

    assign we_o       = w_fire;
    assign aw_clear_o = w_fire;
    assign w_clear_o  = w_fire;
    assign re_o       = (r_state == R_FETCH);
    assign ar_clear_o = r_load;
    assign take_o     = w_fire || r_load;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            w_state <= W_IDLE;
            w_cnt   <= '0;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (w_fire) begin
                        w_cnt   <= delay_i;
                        w_state <= W_WAIT;
                    end
                end
                W_WAIT: begin
                    if (w_cnt == '0) begin
                        w_state <= W_RESP;
                    end else begin
                        w_cnt <= w_cnt - 1'b1;
                    end
                end
                W_RESP: begin
                    if (bready_i) begin
                        w_state <= W_IDLE;
                    end
                end
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            r_state <= R_IDLE;
            r_cnt   <= '0;
        end else begin
            case (r_state)
                R_IDLE: begin
                    if (ar_full_i) begin
                        r_state <= R_FETCH;
                    end
                end
                // re stays high while waiting for the delay value
                R_FETCH: begin
                    if (r_load) begin
                        r_cnt   <= delay_i;
                        r_state <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (r_cnt == '0) begin
                        r_state <= R_RESP;
                    end else begin
                        r_cnt <= r_cnt - 1'b1;
                    end
                end
                R_RESP: begin
                    if (rready_i) begin
                        r_state <= R_IDLE;
                    end
                end
                default: r_state <= R_IDLE;
            endcase
        end
    end

    // response registers
    always_ff @(posedge aclk) begin
        if (w_fire) begin
            bresp_q <= w_ok_i ? RESP_OKAY : RESP_SLVERR;
        end
        if (r_load) begin
            rresp_q <= r_ok_i ? RESP_OKAY : RESP_SLVERR;
        end
        // array output settled since fetch
        if (r_state == R_WAIT && r_cnt == '0) begin
            rdata_q <= rdata_i;
        end
    end

    assign bvalid_o = (w_state == W_RESP);
    assign bresp_o  = bresp_q;
    assign rvalid_o = (r_state == R_RESP);
    assign rdata_o  = rdata_q;
    assign rresp_o  = rresp_q;

    a_b_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
        else $error("b response dropped before bready");

    a_r_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
        else $error("r response dropped or changed before rready");

endmodule

/* hdl/axi_sram_pkg.sv */
package axi_sram_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // word array, index taken from address bits 9:2
    localparam int MEM_DEPTH = 256;
    localparam int IDX_W     = 8;

    // wait count 0..15 cycles
    localparam int DELAY_W = 4;

    // 16-bit galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    localparam int              LFSR_W    = 16;
    localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // write-data beat as held in the w channel register
    typedef struct packed {
        data_t data;
        strb_t strb;
    } wpay_t;

endpackage

/* hdl/axi_sram_top.sv */
module axi_sram_top (
    input  logic                aclk,
    input  logic                areset_n,
    // write address
    input  logic                awvalid_i,
    output logic                awready_o,
    input  axi_sram_pkg::addr_t awaddr_i,
    // write data
    input  logic                wvalid_i,
    output logic                wready_o,
    input  axi_sram_pkg::data_t wdata_i,
    input  axi_sram_pkg::strb_t wstrb_i,
    // write response
    output logic                bvalid_o,
    input  logic                bready_i,
    output axi_sram_pkg::resp_t bresp_o,
    // read address
    input  logic                arvalid_i,
    output logic                arready_o,
    input  axi_sram_pkg::addr_t araddr_i,
    // read data
    output logic                rvalid_o,
    input  logic                rready_i,
    output axi_sram_pkg::data_t rdata_o,
    output axi_sram_pkg::resp_t rresp_o
);

    import axi_sram_pkg::*;

    addr_t              aw_addr;
    wpay_t              w_pay;
    addr_t              ar_addr;
    logic               aw_full;
    logic               w_full;
    logic               ar_full;
    logic               aw_clear;
    logic               w_clear;
    logic               ar_clear;
    logic               we;
    logic               re;
    logic               w_ok;
    logic               r_ok;
    logic               take;
    logic [DELAY_W-1:0] delay;
    data_t              array_rdata;

    chan_hold #(.payload_t(addr_t)) aw_hold (
        .aclk(aclk), .areset_n(areset_n), .valid_i(awvalid_i), .payload_i(awaddr_i),
        .clear_i(aw_clear), .ready_o(awready_o), .full_o(aw_full), .payload_o(aw_addr)
    );

    chan_hold #(.payload_t(wpay_t)) w_hold (
        .aclk(aclk), .areset_n(areset_n), .valid_i(wvalid_i),
        .payload_i(wpay_t'{data: wdata_i, strb: wstrb_i}),
        .clear_i(w_clear), .ready_o(wready_o), .full_o(w_full), .payload_o(w_pay)
    );

    chan_hold #(.payload_t(addr_t)) ar_hold (
        .aclk(aclk), .areset_n(areset_n), .valid_i(arvalid_i), .payload_i(araddr_i),
        .clear_i(ar_clear), .ready_o(arready_o), .full_o(ar_full), .payload_o(ar_addr)
    );

    lfsr_delay u_lfsr (
        .aclk(aclk), .areset_n(areset_n), .take_i(take), .delay_o(delay)
    );

    sram_array u_array (
        .aclk(aclk), .areset_n(areset_n),
        .we_i(we), .waddr_i(aw_addr), .wdata_i(w_pay.data), .wstrb_i(w_pay.strb),
        .re_i(re), .raddr_i(ar_addr),
        .rdata_o(array_rdata), .w_ok_o(w_ok), .r_ok_o(r_ok)
    );

    axi_sram_ctrl u_ctrl (
        .aclk(aclk), .areset_n(areset_n),
        .aw_full_i(aw_full), .w_full_i(w_full), .ar_full_i(ar_full),
        .w_ok_i(w_ok), .r_ok_i(r_ok), .rdata_i(array_rdata), .delay_i(delay),
        .bready_i(bready_i), .rready_i(rready_i),
        .aw_clear_o(aw_clear), .w_clear_o(w_clear), .ar_clear_o(ar_clear),
        .we_o(we), .re_o(re), .take_o(take),
        .bvalid_o(bvalid_o), .bresp_o(bresp_o),
        .rvalid_o(rvalid_o), .rdata_o(rdata_o), .rresp_o(rresp_o)
    );

endmodule

/* hdl/chan_hold.sv */
module chan_hold #(
    parameter type payload_t = axi_sram_pkg::addr_t
) (
    input  logic     aclk,
    input  logic     areset_n,
    input  logic     valid_i,
    input  payload_t payload_i,
    input  logic     clear_i,
    output logic     ready_o,
    output logic     full_o,
    output payload_t payload_o
);

    logic     full_q;
    payload_t payload_q;
    logic     load;

    // take a beat only while empty
    assign load = valid_i && !full_q;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (clear_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            payload_q <= payload_i;
        end
    end

    assign ready_o   = !full_q;
    assign full_o    = full_q;
    assign payload_o = payload_q;

    // control must only release a beat it has seen
    a_clear_when_full: assert property (@(posedge aclk) disable iff (!areset_n)
        clear_i |-> full_q)
        else $error("chan_hold cleared while empty");

endmodule

/* hdl/lfsr_delay.sv */
module lfsr_delay (
    input  logic                             aclk,
    input  logic                             areset_n,
    input  logic                             take_i,
    output logic [axi_sram_pkg::DELAY_W-1:0] delay_o
);

    import axi_sram_pkg::*;

    logic [LFSR_W-1:0] state_q;
    logic [LFSR_W-1:0] step_one;
    logic [LFSR_W-1:0] step_two;

    // one galois shift, right-shifting form
    function automatic logic [LFSR_W-1:0] lfsr_step(input logic [LFSR_W-1:0] s);
        lfsr_step = {1'b0, s[LFSR_W-1:1]} ^ (s[0] ? LFSR_TAPS : '0);
    endfunction

    assign step_one = lfsr_step(state_q);
    assign step_two = lfsr_step(step_one);

    // free running; a take adds one extra step
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            state_q <= LFSR_SEED;
        end else if (take_i) begin
            state_q <= step_two;
        end else begin
            state_q <= step_one;
        end
    end

    assign delay_o = state_q[DELAY_W-1:0];

    a_state_nonzero: assert property (@(posedge aclk) disable iff (!areset_n)
        state_q != '0)
        else $error("lfsr locked up in the all-zero state");

endmodule

/* hdl/sram_array.sv */
module sram_array (
    input  logic                aclk,
    input  logic                areset_n,
    input  logic                we_i,
    input  axi_sram_pkg::addr_t waddr_i,
    input  axi_sram_pkg::data_t wdata_i,
    input  axi_sram_pkg::strb_t wstrb_i,
    input  logic                re_i,
    input  axi_sram_pkg::addr_t raddr_i,
    output axi_sram_pkg::data_t rdata_o,
    output logic                w_ok_o,
    output logic                r_ok_o
);

    import axi_sram_pkg::*;

    data_t            mem [MEM_DEPTH];
    data_t            rdata_q;
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;

    // word index from bits 9:2, anything above must be zero
    assign widx   = waddr_i[IDX_W+1:2];
    assign ridx   = raddr_i[IDX_W+1:2];
    assign w_ok_o = ~|waddr_i[ADDR_W-1:IDX_W+2];
    assign r_ok_o = ~|raddr_i[ADDR_W-1:IDX_W+2];

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i && w_ok_o) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    mem[widx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // out of range reads give zero
    always_ff @(posedge aclk) begin
        if (re_i) begin
            rdata_q <= r_ok_o ? mem[ridx] : '0;
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* project.f */
hdl/axi_sram_pkg.sv
hdl/chan_hold.sv
hdl/lfsr_delay.sv
hdl/sram_array.sv
hdl/axi_sram_ctrl.sv
hdl/axi_sram_top.sv
tb/tb_axi_sram.sv

/* tb/axi_sram_stim.txt */
# op addr data strb order exp_rdata exp_resp (hex, order decimal: 0 aw first, 1 w first)
# op W write, R read, X write and read of the same address issued in one cycle
R 00000010 00000000 0 0 00000000 0
W 00000010 deadbeef f 0 00000000 0
R 00000010 00000000 0 0 deadbeef 0
W 00000014 12345678 f 1 00000000 0
R 00000014 00000000 0 0 12345678 0
W 00000010 aabbccdd 5 0 00000000 0
R 00000010 00000000 0 0 debbbedd 0
W 00000014 ffeeddcc a 1 00000000 0
R 00000014 00000000 0 0 ff34dd78 0
W 00000400 11111111 f 0 00000000 2
R 00000000 00000000 0 0 00000000 0
R 00000400 00000000 0 0 00000000 2
W 80000010 cafef00d f 1 00000000 2
R 00000010 00000000 0 0 debbbedd 0
R 80000014 00000000 0 0 00000000 2
W 000003fc 0badf00d f 1 00000000 0
R 000003fc 00000000 0 0 0badf00d 0
W 00000022 a5a5a5a5 3 0 00000000 0
R 00000020 00000000 0 0 0000a5a5 0
X 00000020 5a5a5a5a c 0 5a5aa5a5 0
R 00000020 00000000 0 0 5a5aa5a5 0
X 00000800 77777777 f 0 00000000 2
W 00000100 01020304 f 1 00000000 0
R 00000104 00000000 0 0 00000000 0
R 00000100 00000000 0 0 01020304 0

/* tb/tb_axi_sram.sv */
module tb_axi_sram;

    import axi_sram_pkg::*;

    logic  aclk;
    logic  areset_n;
    logic  awvalid_i;
    logic  awready_o;
    addr_t awaddr_i;
    logic  wvalid_i;
    logic  wready_o;
    data_t wdata_i;
    strb_t wstrb_i;
    logic  bvalid_o;
    logic  bready_i;
    resp_t bresp_o;
    logic  arvalid_i;
    logic  arready_o;
    addr_t araddr_i;
    logic  rvalid_o;
    logic  rready_i;
    data_t rdata_o;
    resp_t rresp_o;

    // one entry per stimulus line in each queue
    byte         op_q[$];
    addr_t       addr_q[$];
    data_t       data_q[$];
    strb_t       strb_q[$];
    int          order_q[$];
    data_t       exp_data_q[$];
    resp_t       exp_resp_q[$];

    int          data_errs  = 0;
    int          resp_errs  = 0;
    int          other_errs = 0;
    int          cycles     = 0;
    int          limit      = 1000;
    logic [31:0] rng        = 32'd60866;

    axi_sram_top axi_sram_top_inst (
        .aclk(aclk), .areset_n(areset_n),
        .awvalid_i(awvalid_i), .awready_o(awready_o), .awaddr_i(awaddr_i),
        .wvalid_i(wvalid_i), .wready_o(wready_o), .wdata_i(wdata_i), .wstrb_i(wstrb_i),
        .bvalid_o(bvalid_o), .bready_i(bready_i), .bresp_o(bresp_o),
        .arvalid_i(arvalid_i), .arready_o(arready_o), .araddr_i(araddr_i),
        .rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o), .rresp_o(rresp_o)
    );

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            resp_errs++;
        end
    endtask

    // a full holder must hold off the next beat
    task automatic check_ready_low(input string chan, input logic ready);
        if (ready !== 1'b0) begin
            $display("%s ready still high after the beat was taken", chan);
            other_errs++;
        end
    endtask

    task automatic report_and_finish();
        $display("summary: %0d data errors, %0d response errors, %0d other errors",
                 data_errs, resp_errs, other_errs);
        if (data_errs + resp_errs + other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic read_stim();
        int    fd;
        string line;
        byte   op;
        addr_t a;
        data_t d;
        strb_t s;
        int    o;
        data_t e;
        resp_t r;
        fd = $fopen("tb/axi_sram_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/axi_sram_stim.txt");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) break;
                // skip blank and comment lines
                if (line.len() < 2 || line[0] == "#") continue;
                if ($sscanf(line, "%c %h %h %h %d %h %h", op, a, d, s, o, e, r) == 7) begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    strb_q.push_back(s);
                    order_q.push_back(o);
                    exp_data_q.push_back(e);
                    exp_resp_q.push_back(r);
                end
            end
            $fclose(fd);
        end
    endtask

    // each sender holds valid until the beat is taken
    task automatic send_aw(input addr_t addr);
        awaddr_i  = addr;
        awvalid_i = 1'b1;
        @(negedge aclk);
        while (!awready_o) @(negedge aclk);
        @(posedge aclk);
        #1 awvalid_i = 1'b0;
        check_ready_low("aw", awready_o);
    endtask

    task automatic send_w(input data_t data, input strb_t strb);
        wdata_i  = data;
        wstrb_i  = strb;
        wvalid_i = 1'b1;
        @(negedge aclk);
        while (!wready_o) @(negedge aclk);
        @(posedge aclk);
        #1 wvalid_i = 1'b0;
        check_ready_low("w", wready_o);
    endtask

    task automatic send_ar(input addr_t addr);
        araddr_i  = addr;
        arvalid_i = 1'b1;
        @(negedge aclk);
        while (!arready_o) @(negedge aclk);
        @(posedge aclk);
        #1 arvalid_i = 1'b0;
        check_ready_low("ar", arready_o);
    endtask

    task automatic wait_b(input string name, input resp_t exp);
        int    stall;
        resp_t held;
        @(negedge aclk);
        while (!bvalid_o) @(negedge aclk);
        held  = bresp_o;
        rng   = xorshift32(rng);
        stall = rng % 8;
        repeat (stall) begin
            @(negedge aclk);
            if (!bvalid_o || bresp_o !== held) begin
                $display("%s: write response changed while stalled", name);
                other_errs++;
            end
        end
        @(posedge aclk);
        #1 bready_i = 1'b1;
        @(negedge aclk);
        check_resp({name, "_bresp"}, exp, bresp_o);
        @(posedge aclk);
        #1 bready_i = 1'b0;
    endtask

    task automatic wait_r(input string name, input data_t exp_d, input resp_t exp_r);
        int    stall;
        data_t held_d;
        resp_t held_r;
        @(negedge aclk);
        while (!rvalid_o) @(negedge aclk);
        held_d = rdata_o;
        held_r = rresp_o;
        rng    = xorshift32(rng);
        stall  = rng % 8;
        repeat (stall) begin
            @(negedge aclk);
            if (!rvalid_o || rdata_o !== held_d || rresp_o !== held_r) begin
                $display("%s: read response changed while stalled", name);
                other_errs++;
            end
        end
        @(posedge aclk);
        #1 rready_i = 1'b1;
        @(negedge aclk);
        check_data({name, "_rdata"}, exp_d, rdata_o);
        check_resp({name, "_rresp"}, exp_r, rresp_o);
        @(posedge aclk);
        #1 rready_i = 1'b0;
    endtask

    // run ends here if a response never arrives
    always @(posedge aclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: no response from the DUT within %0d cycles", limit);
            other_errs++;
            report_and_finish();
        end
    end

    initial begin
        string name;
        areset_n  = 1'b0;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        bready_i  = 1'b0;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        rready_i  = 1'b0;
        read_stim();
        // worst case per line is a 16 cycle delay plus 7 stall cycles
        limit = op_q.size() * 40 + 20;
        repeat (4) @(posedge aclk);
        #1 areset_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            name = $sformatf("line%0d_%c", i + 1, op_q[i]);
            case (op_q[i])
                "W": begin
                    if (order_q[i] == 1) begin
                        send_w(data_q[i], strb_q[i]);
                        send_aw(addr_q[i]);
                    end else begin
                        send_aw(addr_q[i]);
                        send_w(data_q[i], strb_q[i]);
                    end
                    wait_b(name, exp_resp_q[i]);
                end
                "R": begin
                    send_ar(addr_q[i]);
                    wait_r(name, exp_data_q[i], exp_resp_q[i]);
                end
                "X": begin
                    fork
                        send_aw(addr_q[i]);
                        send_w(data_q[i], strb_q[i]);
                        send_ar(addr_q[i]);
                    join
                    fork
                        wait_b(name, exp_resp_q[i]);
                        wait_r(name, exp_data_q[i], exp_resp_q[i]);
                    join
                end
                default: begin
                    $display("%s: unknown operation in the stimulus file", name);
                    other_errs++;
                end
            endcase
        end
        if (op_q.size() == 0) begin
            $display("no transactions found in the stimulus file");
            other_errs++;
        end
        report_and_finish();
    end

endmodule
